// ==== dv/extMemModel.sv ====
module extMemModel (
    input  logic SPI_clk,
    input  logic rst,
    input  logic extEn,
    input  logic extOen,
    input  logic [31:0] extBusOut,
    output logic [31:0] extBusIn
);
    timeunit 1ns;
    timeprecision 1ps;
    import extPkg::*;

    logic [31:0] mem [4096];
    extCmdT cmdWord;
    logic [9:0] len;
    logic [9:0] idx;
    logic [11:0] wordAddr;
    logic [1:0] step; // 0 idle, 1 length next, 2 read, 3 write.
    int gap;

    assign wordAddr = cmdWord.addr[11:0] + {2'b00, idx};

    initial begin
        extBusIn = '0;
        for (int a = 0; a < 4096; a++)
            mem[a] = 32'(a) ^ 32'h5A5A_0000;
    end

    always @(posedge SPI_clk) begin
        if (rst) begin
            step <= 2'd0;
            extBusIn <= '0;
        end else begin
            case (step)
                2'd0: begin
                    if (extEn && extOen) begin
                        cmdWord <= extBusOut;
                        step <= 2'd1;
                    end
                end
                2'd1: begin
                    len <= extBusOut[9:0];
                    idx <= '0;
                    gap <= extReadLatency - 1;
                    step <= cmdWord.write ? 2'd3 : 2'd2;
                end
                2'd2: begin
                    if (gap > 1) begin
                        gap <= gap - 1;
                    end else begin
                        extBusIn <= mem[wordAddr]; // Seen by the DUT next cycle.
                        idx <= idx + 1'b1;
                        if (idx == len - 1'b1)
                            step <= 2'd0;
                    end
                end
                default: begin
                    if (extOen) begin
                        mem[wordAddr] <= extBusOut;
                        idx <= idx + 1'b1;
                        if (idx == len - 1'b1)
                            step <= 2'd0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== dv/memoryController_props.sv ====
module memoryController_props (
    input  logic SPI_clk,
    input  logic rst,
    input  logic busy,
    input  logic extEn,
    input  logic extOen,
    input  logic dcCe,
    input  logic dcWe,
    input  logic icCe,
    input  logic icWe
);
    timeunit 1ns;
    timeprecision 1ps;
    import extPkg::*;

    // Longest burst plus command, length and wait cycles.
    localparam int busyBound = 1023 + extReadLatency + 4;

    int busyCycles;

    always @(posedge SPI_clk) begin
        if (rst || !busy)
            busyCycles <= 0;
        else
            busyCycles <= busyCycles + 1;
    end

    oenOpened: assert property (@(posedge SPI_clk) disable iff (rst)
        $rose(extOen) |-> $rose(extEn))
        else $error("extOen rose without extEn opening a transfer");

    busyBounded: assert property (@(posedge SPI_clk) disable iff (rst)
        busyCycles <= busyBound)
        else $error("controller busy for longer than any burst allows");

    noIdleWrite: assert property (@(posedge SPI_clk) disable iff (rst)
        !busy |-> !((dcCe && dcWe) || (icCe && icWe)))
        else $error("cache write from the controller while idle");

endmodule

bind memoryController memoryController_props u_props (
    .SPI_clk(SPI_clk),
    .rst(rst),
    .busy(busy),
    .extEn(extEn),
    .extOen(extOen),
    .dcCe(dcReq.ce),
    .dcWe(dcReq.we),
    .icCe(icReq.ce),
    .icWe(icReq.we)
);

// ==== dv/tbMemSubsystem.sv ====
module tbMemSubsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import memPkg::*;

    localparam int resetCycles = 4;

    typedef enum {opWrite, opRead, opWaitIdle, opConsole} kindT;

    typedef struct {
        string name;
        kindT kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] sel;
        logic [31:0] expected;
    } rowT;

    logic SPI_clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [3:0] wbSel;
    logic [31:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic wbAck;
    logic extEn;
    logic extOen;
    logic [31:0] extBusOut;
    logic [31:0] extBusIn;
    logic spiSclk;
    logic spiMosi;

    rowT rows[$];
    logic [7:0] consoleExp[$];
    logic [7:0] rxBytes[$];
    int extAddrQ[$];
    dcWordT extDataQ[$];
    logic [31:0] lfsrState = 32'hd1fe;
    int cycleLimit = 0;
    int cycles = 0;
    int wordErrors = 0;
    int byteErrors = 0;
    int extErrors = 0;
    int otherErrors = 0;

    memSubsystem u_dut (.*);

    extMemModel u_ext (
        .SPI_clk(SPI_clk),
        .rst(rst),
        .extEn(extEn),
        .extOen(extOen),
        .extBusOut(extBusOut),
        .extBusIn(extBusIn)
    );

    initial begin
        SPI_clk = 1'b0;
        forever #20 SPI_clk = ~SPI_clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] nextRandom();
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < 32; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] cmdValue(logic wr, logic ic, int len, int sram);
        return {10'b0, wr, ic, 10'(len), 10'(sram)};
    endfunction

    function automatic logic [31:0] dcAddr(int word);
        return dcBase + 32'(word * 4);
    endfunction

    function automatic logic [31:0] icAddr(int word);
        return icBase + 32'(word * 4);
    endfunction

    function automatic dcWordT extInit(int addr);
        return 32'(addr) ^ 32'h5A5A_0000;
    endfunction

    function automatic void addRow(string name, kindT kind, logic [31:0] addr,
                                   logic [31:0] data, logic [3:0] sel, logic [31:0] expected);
        rowT r;
        r = '{name, kind, addr, data, sel, expected};
        rows.push_back(r);
    endfunction

    task automatic buildTable();
        dcWordT value;
        addRow("dc w5 full", opWrite, dcAddr(5), 32'h1122_3344, 4'hF, '0);
        addRow("dc w5 bytes 0 2", opWrite, dcAddr(5), 32'hAABB_CCDD, 4'b0101, '0);
        addRow("dc w5 merged", opRead, dcAddr(5), '0, 4'hF, 32'h11BB_33DD);
        addRow("dc w6 full", opWrite, dcAddr(6), 32'h0102_0304, 4'hF, '0);
        addRow("dc w6 byte 3", opWrite, dcAddr(6), 32'hFF00_0000, 4'b1000, '0);
        addRow("dc w6 merged", opRead, dcAddr(6), '0, 4'hF, 32'hFF02_0304);
        // DMA read of 16 words into the data cache.
        addRow("ext addr 0x40", opWrite, regExtAddr, 32'h40, 4'hF, '0);
        addRow("dc dma start", opWrite, regCmd, cmdValue(1'b0, 1'b0, 16, 100), 4'hF, '0);
        addRow("status busy", opRead, regStatus, '0, 4'hF, 32'h8000_0000);
        addRow("dc dma done", opWaitIdle, regStatus, '0, 4'hF, 32'd16);
        for (int i = 0; i < 16; i += 5)
            addRow($sformatf("dc dma w%0d", i), opRead, dcAddr(100 + i), '0, 4'hF,
                   extInit(32'h40 + i));
        // Icache pairs, even word low half.
        addRow("ext addr 0x300", opWrite, regExtAddr, 32'h300, 4'hF, '0);
        addRow("ic dma start", opWrite, regCmd, cmdValue(1'b0, 1'b1, 8, 20), 4'hF, '0);
        addRow("ic dma done", opWaitIdle, regStatus, '0, 4'hF, 32'd8);
        for (int i = 0; i < 8; i++)
            addRow($sformatf("ic half %0d", i), opRead, icAddr(40 + i), '0, 4'hF,
                   extInit(32'h300 + i));
        // Random words out to external memory.
        for (int i = 0; i < 8; i++) begin
            value = nextRandom();
            addRow($sformatf("dc rand w%0d", 200 + i), opWrite, dcAddr(200 + i), value,
                   4'hF, '0);
            extAddrQ.push_back(32'h800 + i);
            extDataQ.push_back(value);
        end
        addRow("ext addr 0x800", opWrite, regExtAddr, 32'h800, 4'hF, '0);
        addRow("ext dma start", opWrite, regCmd, cmdValue(1'b1, 1'b0, 8, 200), 4'hF, '0);
        addRow("ext dma done", opWaitIdle, regStatus, '0, 4'hF, 32'd8);
        // Expected bit 0 on a regCmd write marks a command issued during a DMA.
        addRow("ext addr 0x200", opWrite, regExtAddr, 32'h200, 4'hF, '0);
        addRow("dma1 start", opWrite, regCmd, cmdValue(1'b0, 1'b0, 32, 300), 4'hF, '0);
        addRow("ext addr 0x100", opWrite, regExtAddr, 32'h100, 4'hF, '0);
        addRow("dma2 start held", opWrite, regCmd, cmdValue(1'b0, 1'b0, 16, 400), 4'hF, 32'd1);
        addRow("dc w7 during dma", opWrite, dcAddr(7), 32'hCAFE_F00D, 4'hF, '0);
        addRow("dc w7 readback", opRead, dcAddr(7), '0, 4'hF, 32'hCAFE_F00D);
        addRow("dc w5 during dma", opRead, dcAddr(5), '0, 4'hF, 32'h11BB_33DD);
        addRow("dma2 done", opWaitIdle, regStatus, '0, 4'hF, 32'd16);
        addRow("dma1 first", opRead, dcAddr(300), '0, 4'hF, extInit(32'h200));
        addRow("dma1 last", opRead, dcAddr(331), '0, 4'hF, extInit(32'h21F));
        addRow("dma2 first", opRead, dcAddr(400), '0, 4'hF, extInit(32'h100));
        addRow("dma2 last", opRead, dcAddr(415), '0, 4'hF, extInit(32'h10F));
        addRow("console a5", opConsole, regConsole, 32'hA5, 4'h1, '0);
        addRow("console 3c", opConsole, regConsole, 32'h3C, 4'h1, '0);
    endtask

    function automatic int testCycles();
        int total;
        total = 0;
        foreach (rows[i]) begin
            total += 40;
            if (rows[i].kind == opWrite && rows[i].addr == regCmd)
                total += 4 * int'(rows[i].data[19:10]);
            if (rows[i].kind == opConsole)
                total += 20;
        end
        return total;
    endfunction

    task automatic checkWord(input string name, input dcWordT expected, input dcWordT actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            wordErrors++;
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            byteErrors++;
        end
    endtask

    task automatic checkExt(input string name, input dcWordT expected, input dcWordT actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            extErrors++;
        end
    endtask

    // One classic cycle, held until ack.
    task automatic wbAccess(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output dcWordT rdat,
                            output logic busyAtIssue, output logic busyAtAck);
        @(posedge SPI_clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= we;
        wbAdr <= adr;
        wbDatW <= dat;
        wbSel <= sel;
        @(negedge SPI_clk);
        busyAtIssue = extEn;
        while (!wbAck)
            @(negedge SPI_clk);
        rdat = wbDatR;
        busyAtAck = extEn;
        @(posedge SPI_clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    task automatic applyRow(input rowT row);
        dcWordT rd;
        logic busyIssue;
        logic busyAck;
        case (row.kind)
            opWrite: begin
                wbAccess(1'b1, row.addr, row.data, row.sel, rd, busyIssue, busyAck);
                if (row.addr == regCmd && busyAck) begin
                    $display("%s: command acked while the controller was still busy", row.name);
                    otherErrors++;
                end
                if (row.addr == regCmd && row.expected[0] && !busyIssue) begin
                    $display("%s: command was not issued during a running DMA", row.name);
                    otherErrors++;
                end
            end
            opRead: begin
                wbAccess(1'b0, row.addr, '0, row.sel, rd, busyIssue, busyAck);
                checkWord(row.name, row.expected, rd);
            end
            opWaitIdle: begin
                rd = 32'h8000_0000;
                while (rd[31])
                    wbAccess(1'b0, regStatus, '0, 4'hF, rd, busyIssue, busyAck);
                checkWord(row.name, row.expected, rd);
            end
            default: begin
                wbAccess(1'b1, row.addr, row.data, row.sel, rd, busyIssue, busyAck);
                consoleExp.push_back(row.data[7:0]);
            end
        endcase
    endtask

    // Bits are stable while spiSclk is high.
    initial begin : spiCapture
        logic [7:0] shift;
        int nBits;
        shift = '0;
        nBits = 0;
        @(negedge rst);
        forever begin
            @(posedge spiSclk);
            shift = {shift[6:0], spiMosi};
            nBits++;
            if (nBits == 8) begin
                rxBytes.push_back(shift);
                nBits = 0;
            end
        end
    end

    initial begin : watchdog
        wait (cycleLimit > 0);
        while (cycles < cycleLimit) begin
            @(posedge SPI_clk);
            cycles++;
        end
        $display("Run hung: no finish after %0d cycles", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbSel = '0;
        wbAdr = '0;
        wbDatW = '0;
        buildTable();
        cycleLimit = resetCycles + testCycles();
        repeat (resetCycles) @(posedge SPI_clk);
        rst <= 1'b0;
        foreach (rows[i])
            applyRow(rows[i]);
        while (rxBytes.size() < consoleExp.size())
            @(negedge SPI_clk);
        foreach (consoleExp[i])
            checkByte($sformatf("console byte %0d", i), consoleExp[i], rxBytes[i]);
        foreach (extAddrQ[i])
            checkExt($sformatf("ext word %0h", extAddrQ[i]), extDataQ[i], u_ext.mem[extAddrQ[i]]);
        $display("Errors: word %0d, byte %0d, ext %0d, other %0d",
                 wordErrors, byteErrors, extErrors, otherErrors);
        if (wordErrors + byteErrors + extErrors + otherErrors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/memPkg.sv
hw/extPkg.sv
hw/cacheIf.sv
hw/cacheBank.sv
hw/memoryController.sv
hw/wbMemPort.sv
hw/spiTx.sv
hw/memSubsystem.sv
dv/extMemModel.sv
dv/memoryController_props.sv
dv/tbMemSubsystem.sv

// ==== hw/cacheBank.sv ====
module cacheBank #(
    parameter type wordT = memPkg::dcWordT,
    parameter int depth = memPkg::dcDepth
) (
    input  logic SPI_clk,
    input  logic rst,
    cacheIf.bank ctrl,
    cacheIf.bank core
);
    wordT mem [depth];
    logic selWe;
    logic [$bits(wordT)/8-1:0] selWm;
    logic [$clog2(depth)-1:0] selAddr;
    wordT selData;

    // Controller always wins.
    assign ctrl.gnt = ctrl.ce;
    assign core.gnt = core.ce && !ctrl.ce;

    always_comb begin
        if (ctrl.ce) begin
            selWe = ctrl.we;
            selWm = ctrl.wm;
            selAddr = ctrl.addr[$clog2(depth)-1:0];
            selData = ctrl.wdata;
        end else begin
            selWe = core.ce && core.we;
            selWm = core.wm;
            selAddr = core.addr[$clog2(depth)-1:0];
            selData = core.wdata;
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (!rst && selWe) begin
            for (int b = 0; b < $bits(wordT) / 8; b++) begin
                if (selWm[b])
                    mem[selAddr][8*b +: 8] <= selData[8*b +: 8];
            end
        end
        if (ctrl.gnt && !ctrl.we)
            ctrl.rdata <= mem[selAddr];
        if (core.gnt && !core.we)
            core.rdata <= mem[selAddr]; // Valid the cycle after gnt.
    end

endmodule

// ==== hw/cacheIf.sv ====
interface cacheIf #(
    parameter type wordT = memPkg::dcWordT
);
    logic ce;
    logic we;
    logic [$bits(wordT)/8-1:0] wm; // One bit per byte.
    memPkg::sramAddrT addr;
    wordT wdata;
    wordT rdata;
    logic gnt;

    modport requester (
        output ce, we, wm, addr, wdata,
        input rdata, gnt
    );

    modport bank (
        input ce, we, wm, addr, wdata,
        output rdata, gnt
    );

endinterface

// ==== hw/extPkg.sv ====
package extPkg;

    typedef logic [29:0] extAddrT;
    typedef logic [9:0] burstLenT;

    localparam int minBurst = 1;
    localparam int extReadLatency = 2; // Cycles from length word to first data.

    // First word of every transfer.
    typedef struct packed {
        logic write;
        logic reserved;
        extAddrT addr;
    } extCmdT;

    // Layout of the command register.
    typedef struct packed {
        logic write; // Cache to external.
        memPkg::cacheIdT cacheId;
        burstLenT len;
        memPkg::sramAddrT sramAddr;
    } mcCmdT;

    typedef struct packed {
        logic busy;
        logic [20:0] reserved;
        burstLenT progress;
    } mcStatusT;

endpackage

// ==== hw/memPkg.sv ====
package memPkg;

    typedef logic [31:0] dcWordT;
    typedef logic [63:0] icWordT;

    localparam int dcDepth = 1024;
    localparam int icDepth = 512;

    typedef logic [9:0] sramAddrT;

    // Cache selector.
    typedef logic cacheIdT;

    localparam cacheIdT cacheData  = 1'b0;
    localparam cacheIdT cacheInstr = 1'b1;

    // Byte addresses seen by the core.
    localparam logic [31:0] dcBase = 32'h0000_0000; // 1024 words.
    localparam logic [31:0] icBase = 32'h0000_1000; // 1024 halves, even word is low half.

    localparam logic [31:0] regExtAddr = 32'h0000_2000;
    localparam logic [31:0] regCmd     = 32'h0000_2004;
    localparam logic [31:0] regStatus  = 32'h0000_2008;
    localparam logic [31:0] regConsole = 32'h0000_200C;

endpackage

// ==== hw/memSubsystem.sv ====
module memSubsystem (
    input  logic SPI_clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [3:0] wbSel,
    input  logic [31:0] wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic wbAck,
    output logic extEn,
    output logic extOen,
    output logic [31:0] extBusOut,
    input  logic [31:0] extBusIn,
    output logic spiSclk,
    output logic spiMosi
);
    import memPkg::*;
    import extPkg::*;

    cacheIf #(.wordT(dcWordT)) dcCtrl ();
    cacheIf #(.wordT(dcWordT)) dcCore ();
    cacheIf #(.wordT(icWordT)) icCtrl ();
    cacheIf #(.wordT(icWordT)) icCore ();

    logic mcStart;
    mcCmdT mcCmd;
    extAddrT mcExtAddr;
    logic mcBusy;
    burstLenT mcProgress;
    logic txValid;
    logic [7:0] txByte;
    logic txBusy;

    cacheBank #(.wordT(dcWordT), .depth(dcDepth)) u_dcBank (
        .SPI_clk(SPI_clk),
        .rst(rst),
        .ctrl(dcCtrl.bank),
        .core(dcCore.bank)
    );

    cacheBank #(.wordT(icWordT), .depth(icDepth)) u_icBank (
        .SPI_clk(SPI_clk),
        .rst(rst),
        .ctrl(icCtrl.bank),
        .core(icCore.bank)
    );

    memoryController u_memCtrl (
        .SPI_clk(SPI_clk),
        .rst(rst),
        .start(mcStart),
        .cmd(mcCmd),
        .extAddr(mcExtAddr),
        .busy(mcBusy),
        .progress(mcProgress),
        .dcReq(dcCtrl.requester),
        .icReq(icCtrl.requester),
        .extEn(extEn),
        .extOen(extOen),
        .extBusOut(extBusOut),
        .extBusIn(extBusIn)
    );

    wbMemPort u_wbPort (
        .SPI_clk(SPI_clk),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbSel(wbSel),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .dcReq(dcCore.requester),
        .icReq(icCore.requester),
        .mcStart(mcStart),
        .mcCmd(mcCmd),
        .mcExtAddr(mcExtAddr),
        .mcBusy(mcBusy),
        .mcProgress(mcProgress),
        .txValid(txValid),
        .txByte(txByte),
        .txBusy(txBusy)
    );

    // Console output.
    spiTx u_spiTx (
        .SPI_clk(SPI_clk),
        .rst(rst),
        .txValid(txValid),
        .txByte(txByte),
        .txBusy(txBusy),
        .spiSclk(spiSclk),
        .spiMosi(spiMosi)
    );

endmodule

// ==== hw/memoryController.sv ====
module memoryController (
    input  logic SPI_clk,
    input  logic rst,
    input  logic start,
    input  extPkg::mcCmdT cmd,
    input  extPkg::extAddrT extAddr,
    output logic busy,
    output extPkg::burstLenT progress,
    cacheIf.requester dcReq,
    cacheIf.requester icReq,
    output logic extEn,
    output logic extOen,
    output logic [31:0] extBusOut,
    input  logic [31:0] extBusIn
);
    import memPkg::*;
    import extPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stCommand,
        stLength,
        stWait,
        stStream
    } stateT;

    stateT state;
    mcCmdT cur;
    extAddrT curExt;
    extCmdT cmdWord;
    burstLenT cnt;
    burstLenT idx;
    logic [1:0] waitCnt;
    logic lastWord;
    logic bankCe;
    logic useIc;
    dcWordT outWord;

    assign busy = state != stIdle;
    assign progress = cnt; // Words moved so far.
    assign lastWord = cnt == cur.len - 1'b1;
    assign useIc = cur.cacheId == cacheInstr;

    always_ff @(posedge SPI_clk) begin
        if (rst) begin
            state <= stIdle;
            cnt <= '0;
            waitCnt <= '0;
        end else begin
            unique case (state)
                stIdle: begin
                    if (start && cmd.len >= minBurst) begin
                        state <= stCommand;
                        cnt <= '0;
                    end
                end
                stCommand: state <= stLength;
                stLength: begin
                    // First read word lands extReadLatency cycles after this one.
                    waitCnt <= 2'(extReadLatency - 2);
                    state <= cur.write ? stStream : stWait;
                end
                stWait: begin
                    if (waitCnt == '0)
                        state <= stStream;
                    else
                        waitCnt <= waitCnt - 1'b1;
                end
                stStream: begin
                    cnt <= cnt + 1'b1;
                    if (lastWord)
                        state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (state == stIdle && start) begin
            cur <= cmd;
            curExt <= extAddr;
        end
    end

    // Write bursts read the bank one word ahead.
    always_comb begin
        idx = cnt;
        bankCe = 1'b0;
        if (cur.write) begin
            if (state == stLength) begin
                idx = '0;
                bankCe = 1'b1;
            end else if (state == stStream && !lastWord) begin
                idx = cnt + 1'b1;
                bankCe = 1'b1;
            end
        end else begin
            bankCe = state == stStream;
        end
    end

    assign dcReq.ce = bankCe && !useIc;
    assign dcReq.we = !cur.write;
    assign dcReq.wm = '1;
    assign dcReq.addr = cur.sramAddr + idx;
    assign dcReq.wdata = extBusIn;

    assign icReq.ce = bankCe && useIc;
    assign icReq.we = !cur.write;
    assign icReq.wm = idx[0] ? 8'hF0 : 8'h0F; // Odd words fill the high half.
    assign icReq.addr = cur.sramAddr + (idx >> 1);
    assign icReq.wdata = {extBusIn, extBusIn};

    assign outWord = !useIc ? dcReq.rdata : (cnt[0] ? icReq.rdata[63:32] : icReq.rdata[31:0]);

    assign cmdWord = '{write: cur.write, reserved: 1'b0, addr: curExt};
    assign extEn = state != stIdle;
    assign extOen = state == stCommand || state == stLength || (state == stStream && cur.write);

    always_comb begin
        unique case (state)
            stCommand: extBusOut = cmdWord;
            stLength: extBusOut = 32'(cur.len);
            stStream: extBusOut = cur.write ? outWord : '0;
            default: extBusOut = '0;
        endcase
    end

endmodule

// ==== hw/spiTx.sv ====
module spiTx (
    input  logic SPI_clk,
    input  logic rst,
    input  logic txValid,
    input  logic [7:0] txByte,
    output logic txBusy,
    output logic spiSclk,
    output logic spiMosi
);
    logic [7:0] shiftReg;
    logic [2:0] bitCnt;
    logic phase; // Second cycle of a bit.

    assign spiSclk = phase;
    assign spiMosi = shiftReg[7]; // MSB first.

    always_ff @(posedge SPI_clk) begin
        if (rst) begin
            txBusy <= 1'b0;
            phase <= 1'b0;
            bitCnt <= '0;
            shiftReg <= '0;
        end else if (!txBusy) begin
            if (txValid) begin
                txBusy <= 1'b1;
                shiftReg <= txByte;
                bitCnt <= '0;
            end
        end else if (!phase) begin
            phase <= 1'b1;
        end else begin
            // Next bit goes out while the clock is low.
            phase <= 1'b0;
            shiftReg <= {shiftReg[6:0], 1'b0};
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == 3'd7)
                txBusy <= 1'b0;
        end
    end

endmodule

// ==== hw/wbMemPort.sv ====
module wbMemPort (
    input  logic SPI_clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [3:0] wbSel,
    input  logic [31:0] wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic wbAck,
    cacheIf.requester dcReq,
    cacheIf.requester icReq,
    output logic mcStart,
    output extPkg::mcCmdT mcCmd,
    output extPkg::extAddrT mcExtAddr,
    input  logic mcBusy,
    input  extPkg::burstLenT mcProgress,
    output logic txValid,
    output logic [7:0] txByte,
    input  logic txBusy
);
    import memPkg::*;
    import extPkg::*;

    logic req;
    logic hitDc;
    logic hitIc;
    logic hitExt;
    logic hitCmd;
    logic hitStatus;
    logic hitConsole;
    logic cmdFree;
    logic txFree;
    mcStatusT status;

    assign req = wbCyc && wbStb && !wbAck;
    assign hitDc = wbAdr[31:12] == dcBase[31:12];
    assign hitIc = wbAdr[31:12] == icBase[31:12];
    assign hitExt = wbAdr[31:2] == regExtAddr[31:2];
    assign hitCmd = wbAdr[31:2] == regCmd[31:2];
    assign hitStatus = wbAdr[31:2] == regStatus[31:2];
    assign hitConsole = wbAdr[31:2] == regConsole[31:2];

    // Back-pressure while the target is still working.
    assign cmdFree = !mcBusy && !mcStart;
    assign txFree = !txBusy && !txValid;

    assign status = '{busy: mcBusy, reserved: '0, progress: mcProgress};

    assign dcReq.ce = req && hitDc;
    assign dcReq.we = wbWe;
    assign dcReq.wm = wbSel;
    assign dcReq.addr = wbAdr[11:2];
    assign dcReq.wdata = wbDatW;

    assign icReq.ce = req && hitIc && !wbWe; // Core writes here are dropped.
    assign icReq.we = 1'b0;
    assign icReq.wm = '0;
    assign icReq.addr = sramAddrT'(wbAdr[11:3]);
    assign icReq.wdata = '0;

    always_ff @(posedge SPI_clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            mcStart <= 1'b0;
            txValid <= 1'b0;
            mcExtAddr <= '0;
        end else begin
            wbAck <= 1'b0;
            mcStart <= 1'b0;
            txValid <= 1'b0;
            if (req) begin
                if (hitDc) begin
                    wbAck <= dcReq.gnt;
                end else if (hitIc) begin
                    wbAck <= wbWe || icReq.gnt;
                end else if (hitCmd && wbWe) begin
                    wbAck <= cmdFree;
                    mcStart <= cmdFree;
                end else if (hitConsole && wbWe) begin
                    wbAck <= txFree;
                    txValid <= txFree;
                end else begin
                    wbAck <= 1'b1;
                    if (hitExt && wbWe)
                        mcExtAddr <= wbDatW[29:0];
                end
            end
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (req && hitCmd && wbWe && cmdFree)
            mcCmd <= wbDatW[21:0];
        if (req && hitConsole && wbWe && txFree)
            txByte <= wbDatW[7:0];
    end

    always_comb begin
        wbDatR = '0;
        if (hitDc)
            wbDatR = dcReq.rdata;
        else if (hitIc)
            wbDatR = wbAdr[2] ? icReq.rdata[63:32] : icReq.rdata[31:0];
        else if (hitExt)
            wbDatR = {2'b00, mcExtAddr};
        else if (hitCmd)
            wbDatR = 32'(mcCmd);
        else if (hitStatus)
            wbDatR = status;
        else if (hitConsole)
            wbDatR = {31'b0, txBusy};
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tbMemSubsystem -f filelist.f -o simMemSubsystem
./obj_dir/simMemSubsystem | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
